//--- files.f
+incdir+tb
src/rv_pkg.sv
src/alu.sv
src/reg_file.sv
src/inst_decoder.sv
src/pc_unit.sv
src/lsu.sv
src/rv_core_top.sv
tb/tb_rv_core.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing -Wno-fatal --top-module tb_rv_core -f files.f \
  -o tb_rv_core > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_rv_core > sim.log 2>&1 || echo "simulator returned an error status"
grep -q "All tests passed" sim.log && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }

//--- src/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu import rv_pkg::*; (
  input  wire alu_op_e     op,
  input  wire [xlen-1:0]   a,
  input  wire [xlen-1:0]   b,
  output logic [xlen-1:0]  result
);

  logic [4:0]      shamt;
  logic            lt_s;
  logic            lt_u;
  logic [xlen-1:0] sra_res;

  assign shamt   = b[4:0];
  assign lt_s    = $signed(a) < $signed(b);
  assign lt_u    = a < b;
  assign sra_res = $signed(a) >>> shamt;

  always_comb begin
    case (op)
      alu_add:  result = a + b;         // also load/store address
      alu_sub:  result = a - b;
      alu_sll:  result = a << shamt;
      alu_slt:  result = {{(xlen-1){1'b0}}, lt_s};
      alu_sltu: result = {{(xlen-1){1'b0}}, lt_u};
      alu_xor:  result = a ^ b;
      alu_srl:  result = a >> shamt;
      alu_sra:  result = sra_res;
      alu_or:   result = a | b;
      alu_and:  result = a & b;
      default:  result = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- src/inst_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module inst_decoder import rv_pkg::*; (
  input  wire [31:0]            inst,
  output logic [reg_addr_w-1:0] rs1_addr,
  output logic [reg_addr_w-1:0] rs2_addr,
  output ctrl_t                 ctrl
);

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic            alt;      // inst[30], sub/sra select
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_s;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_u;
  logic [xlen-1:0] imm_j;

  // extend from bit (bits-1), shared by every immediate format
  function automatic logic [xlen-1:0] sext(input logic [xlen-1:0] v, input int bits);
    logic [xlen-1:0] left;
    left = v << (xlen - bits);
    return $signed(left) >>> (xlen - bits);
  endfunction

  function automatic alu_op_e alu_from_f3(input logic [2:0] f3, input logic sub_sra);
    case (f3)
      3'b000:  return sub_sra ? alu_sub : alu_add;
      3'b001:  return alu_sll;
      3'b010:  return alu_slt;
      3'b011:  return alu_sltu;
      3'b100:  return alu_xor;
      3'b101:  return sub_sra ? alu_sra : alu_srl;
      3'b110:  return alu_or;
      default: return alu_and;
    endcase
  endfunction

  assign opcode   = inst[6:0];
  assign funct3   = inst[14:12];
  assign alt      = inst[30];
  assign rs1_addr = inst[19:15];
  assign rs2_addr = inst[24:20];

  assign imm_i = sext({20'b0, inst[31:20]}, 12);
  assign imm_s = sext({20'b0, inst[31:25], inst[11:7]}, 12);
  assign imm_b = sext({19'b0, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0}, 13);
  assign imm_j = sext({11'b0, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0}, 21);
  assign imm_u = {inst[31:12], 12'b0};

  always_comb begin
    ctrl    = '0;         // unknown opcode: nothing enabled
    ctrl.rd = inst[11:7];
    case (opcode)
      op_lui: begin
        ctrl.reg_we = 1'b1;
        ctrl.wb_sel = wb_imm;
        ctrl.imm    = imm_u;
      end
      op_auipc: begin
        ctrl.reg_we = 1'b1;
        ctrl.wb_sel = wb_pc_imm;
        ctrl.imm    = imm_u;
      end
      op_jal: begin
        ctrl.reg_we = 1'b1;
        ctrl.wb_sel = wb_pc_plus4;
        ctrl.is_jal = 1'b1;
        ctrl.imm    = imm_j;
      end
      op_jalr: begin
        ctrl.reg_we  = 1'b1;
        ctrl.wb_sel  = wb_pc_plus4;
        ctrl.is_jalr = 1'b1;
        ctrl.imm     = imm_i;
      end
      op_branch: begin
        ctrl.is_branch = 1'b1;
        ctrl.mem_size  = funct3;
        ctrl.imm       = imm_b;
      end
      op_load: begin
        ctrl.reg_we      = 1'b1;
        ctrl.mem_re      = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.wb_sel      = wb_load;
        ctrl.mem_size    = funct3;
        ctrl.imm         = imm_i;
      end
      op_store: begin
        ctrl.mem_we      = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.mem_size    = funct3;
        ctrl.imm         = imm_s;
      end
      op_imm: begin
        ctrl.reg_we      = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        // only srai looks at bit 30, addi imm may have it set
        ctrl.alu_op      = alu_from_f3(funct3, alt && (funct3 == 3'b101));
        ctrl.imm         = imm_i;
      end
      op_reg: begin
        ctrl.reg_we = 1'b1;
        ctrl.alu_op = alu_from_f3(funct3, alt);
      end
      op_system: ctrl.is_ebreak = (inst == inst_ebreak);  // ecall/csr fall through as nop
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- src/lsu.sv
`timescale 1ns/10ps
`default_nettype none

module lsu import rv_pkg::*; (
  input  wire ctrl_t       ctrl,
  input  wire [xlen-1:0]   addr,
  input  wire [xlen-1:0]   rs2_data,
  input  wire [xlen-1:0]   rdata,
  input  wire [xlen-1:0]   alu_result,
  input  wire [xlen-1:0]   pc_plus4,
  input  wire [xlen-1:0]   pc_imm,
  input  wire              halted,
  output logic [3:0]       wstrb,
  output logic [xlen-1:0]  wdata,
  output logic             we,
  output logic [xlen-1:0]  wb_data,
  output logic             reg_we
);

  logic [4:0]      lane_shift;   // byte offset in bits
  logic [3:0]      mask;
  logic [xlen-1:0] rdata_sh;
  logic [xlen-1:0] load_data;
  logic            commit;

  assign commit     = ~halted & ~ctrl.is_ebreak;
  assign we         = ctrl.mem_we & commit;
  assign reg_we     = ctrl.reg_we & commit;
  assign lane_shift = {addr[1:0], 3'b000};

  // store side, data moved up to its lane
  assign wdata = rs2_data << lane_shift;

  always_comb begin
    case (ctrl.mem_size)
      f3_byte: mask = 4'b0001 << addr[1:0];
      f3_half: mask = 4'b0011 << addr[1:0];  // offset 2 gives 1100
      default: mask = 4'b1111;
    endcase
  end

  assign wstrb = we ? mask : 4'b0000;

  // load side
  assign rdata_sh = rdata >> lane_shift;

  always_comb begin
    load_data = '0;
    if (ctrl.mem_re) begin
      case (ctrl.mem_size)
        f3_byte:   load_data = {{24{rdata_sh[7]}}, rdata_sh[7:0]};
        f3_half:   load_data = {{16{rdata_sh[15]}}, rdata_sh[15:0]};
        f3_byte_u: load_data = {24'b0, rdata_sh[7:0]};
        f3_half_u: load_data = {16'b0, rdata_sh[15:0]};
        default:   load_data = rdata;    // lw
      endcase
    end
  end

  always_comb begin
    case (ctrl.wb_sel)
      wb_load:     wb_data = load_data;
      wb_pc_plus4: wb_data = pc_plus4;   // link
      wb_imm:      wb_data = ctrl.imm;
      wb_pc_imm:   wb_data = pc_imm;
      default:     wb_data = alu_result;
    endcase
  end

endmodule

`default_nettype wire

//--- src/pc_unit.sv
`timescale 1ns/10ps
`default_nettype none

module pc_unit import rv_pkg::*; #(
  parameter logic [xlen-1:0] reset_pc = 32'h8000_0000
) (
  input  wire             clk,
  input  wire             rst_n,
  input  wire ctrl_t      ctrl,
  input  wire [xlen-1:0]  rs1_data,
  input  wire [xlen-1:0]  rs2_data,
  output logic [xlen-1:0] pc,
  output logic [xlen-1:0] pc_plus4,
  output logic [xlen-1:0] pc_imm,
  output logic            halted
);

  logic            taken;
  logic [xlen-1:0] jalr_sum;
  logic [xlen-1:0] next_pc;

  assign pc_plus4 = pc + 32'd4;
  assign pc_imm   = pc + ctrl.imm;    // branch/jal target, auipc result
  assign jalr_sum = rs1_data + ctrl.imm;

  // branch condition rides in mem_size
  always_comb begin
    case (ctrl.mem_size)
      f3_beq:  taken = (rs1_data == rs2_data);
      f3_bne:  taken = (rs1_data != rs2_data);
      f3_blt:  taken = ($signed(rs1_data) < $signed(rs2_data));
      f3_bge:  taken = ($signed(rs1_data) >= $signed(rs2_data));
      f3_bltu: taken = (rs1_data < rs2_data);
      f3_bgeu: taken = (rs1_data >= rs2_data);
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    if (halted || ctrl.is_ebreak) begin
      next_pc = pc;                     // frozen
    end else if (ctrl.is_jalr) begin
      next_pc = {jalr_sum[xlen-1:1], 1'b0};
    end else if (ctrl.is_jal || (ctrl.is_branch && taken)) begin
      next_pc = pc_imm;
    end else begin
      next_pc = pc_plus4;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc     <= reset_pc;
      halted <= 1'b0;
    end else begin
      pc <= next_pc;
      if (ctrl.is_ebreak) halted <= 1'b1;  // sticky until reset
    end
  end

endmodule

`default_nettype wire

//--- src/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file import rv_pkg::*; (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   we,
  input  wire [reg_addr_w-1:0]  waddr,
  input  wire [xlen-1:0]        wdata,
  input  wire [reg_addr_w-1:0]  rs1_addr,
  input  wire [reg_addr_w-1:0]  rs2_addr,
  output logic [xlen-1:0]       rs1_data,
  output logic [xlen-1:0]       rs2_data
);

  logic [xlen-1:0] regs [1:31];  // x0 not stored

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) regs[i] <= '0;
    end else if (we && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  // x0 reads back zero
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

//--- src/rv_core_top.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core_top import rv_pkg::*; #(
  parameter logic [xlen-1:0] reset_pc = 32'h8000_0000
) (
  input  wire              clk,
  input  wire              rst_n,
  output logic [31:0]      imem_addr,
  input  wire  [31:0]      imem_rdata,
  output logic [xlen-1:0]  dmem_addr,
  output logic             dmem_we,
  output logic [3:0]       dmem_wstrb,
  output logic [xlen-1:0]  dmem_wdata,
  input  wire  [xlen-1:0]  dmem_rdata,
  output logic             halted
);

  ctrl_t                 ctrl;
  logic [reg_addr_w-1:0] rs1_addr;
  logic [reg_addr_w-1:0] rs2_addr;
  logic [xlen-1:0]       rs1_data;
  logic [xlen-1:0]       rs2_data;
  logic [xlen-1:0]       alu_b;
  logic [xlen-1:0]       alu_result;
  logic [xlen-1:0]       pc;
  logic [xlen-1:0]       pc_plus4;
  logic [xlen-1:0]       pc_imm;
  logic [xlen-1:0]       wb_data;
  logic                  reg_we;
  logic                  no_commit;

  assign imem_addr = pc;
  assign dmem_addr = alu_result;
  assign alu_b     = ctrl.alu_src_imm ? ctrl.imm : rs2_data;

  // no stores while held in reset or after ebreak
  assign no_commit = halted | ~rst_n;

  pc_unit #(.reset_pc(reset_pc)) pc_unit_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .ctrl     (ctrl),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .pc       (pc),
    .pc_plus4 (pc_plus4),
    .pc_imm   (pc_imm),
    .halted   (halted)
  );

  inst_decoder inst_decoder_inst (
    .inst     (imem_rdata),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .ctrl     (ctrl)
  );

  reg_file reg_file_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .we       (reg_we),
    .waddr    (ctrl.rd),
    .wdata    (wb_data),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  alu alu_inst (
    .op     (ctrl.alu_op),
    .a      (rs1_data),
    .b      (alu_b),
    .result (alu_result)
  );

  lsu lsu_inst (
    .ctrl       (ctrl),
    .addr       (alu_result),
    .rs2_data   (rs2_data),
    .rdata      (dmem_rdata),
    .alu_result (alu_result),
    .pc_plus4   (pc_plus4),
    .pc_imm     (pc_imm),
    .halted     (no_commit),
    .wstrb      (dmem_wstrb),
    .wdata      (dmem_wdata),
    .we         (dmem_we),
    .wb_data    (wb_data),
    .reg_we     (reg_we)
  );

endmodule

`default_nettype wire

//--- src/rv_pkg.sv
`default_nettype none

package rv_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;

  // major opcodes, inst[6:0]
  localparam logic [6:0] op_lui    = 7'b011_0111;
  localparam logic [6:0] op_auipc  = 7'b001_0111;
  localparam logic [6:0] op_jal    = 7'b110_1111;
  localparam logic [6:0] op_jalr   = 7'b110_0111;
  localparam logic [6:0] op_branch = 7'b110_0011;
  localparam logic [6:0] op_load   = 7'b000_0011;
  localparam logic [6:0] op_store  = 7'b010_0011;
  localparam logic [6:0] op_imm    = 7'b001_0011;
  localparam logic [6:0] op_reg    = 7'b011_0011;
  localparam logic [6:0] op_system = 7'b111_0011;

  // branch conditions
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  // load/store widths
  localparam logic [2:0] f3_byte   = 3'b000;
  localparam logic [2:0] f3_half   = 3'b001;
  localparam logic [2:0] f3_word   = 3'b010;
  localparam logic [2:0] f3_byte_u = 3'b100;
  localparam logic [2:0] f3_half_u = 3'b101;

  localparam logic [31:0] inst_ebreak = 32'h0010_0073;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_e;

  // write-back source
  typedef enum logic [2:0] {
    wb_alu,
    wb_load,
    wb_pc_plus4,
    wb_imm,     // lui
    wb_pc_imm   // auipc
  } wb_sel_e;

  typedef struct packed {
    logic [reg_addr_w-1:0] rd;
    logic                  reg_we;
    alu_op_e               alu_op;
    logic                  alu_src_imm;  // operand b is imm, not rs2
    wb_sel_e               wb_sel;
    logic                  is_branch;
    logic                  is_jal;
    logic                  is_jalr;
    logic                  mem_re;
    logic                  mem_we;
    logic [2:0]            mem_size;     // funct3, also branch condition
    logic                  is_ebreak;
    logic [xlen-1:0]       imm;
  } ctrl_t;

endpackage

`default_nettype wire

//--- tb/rv_iss.svh
`ifndef rv_iss_svh
`define rv_iss_svh

// reference copy of the architectural state
logic [31:0] ref_x [0:31];
logic [31:0] ref_mem [0:127];   // same 512-byte data space as the DUT side
logic [31:0] ref_pc;
logic        ref_halted;

function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
  case (f3)
    3'd0: return alt ? a - b : a + b;
    3'd1: return a << b[4:0];
    3'd2: return {31'b0, $signed(a) < $signed(b)};
    3'd3: return {31'b0, a < b};
    3'd4: return a ^ b;
    3'd5: begin
      if (alt) return $signed(a) >>> b[4:0];
      return a >> b[4:0];
    end
    3'd6: return a | b;
    default: return a & b;
  endcase
endfunction

// retires one instruction and reports its store
task automatic step_model(output logic st_we, output logic [31:0] st_addr,
                          output logic [3:0] st_strb, output logic [31:0] st_data);
  logic [31:0] inst;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] imm_i;
  logic [31:0] res;
  logic [31:0] nxt;
  logic [31:0] addr;
  logic [31:0] word;
  logic        wr;
  logic        taken;
  st_we   = 1'b0;
  st_addr = '0;
  st_strb = '0;
  st_data = '0;
  if (ref_halted) return;
  inst  = prog[ref_pc[9:2]];
  a     = ref_x[inst[19:15]];
  b     = ref_x[inst[24:20]];
  imm_i = {{20{inst[31]}}, inst[31:20]};
  nxt   = ref_pc + 32'd4;
  wr    = 1'b0;
  res   = '0;
  case (inst[6:0])
    7'h37: begin
      wr  = 1'b1;
      res = {inst[31:12], 12'b0};
    end
    7'h17: begin
      wr  = 1'b1;
      res = ref_pc + {inst[31:12], 12'b0};
    end
    7'h6f: begin
      wr  = 1'b1;
      res = nxt;
      nxt = ref_pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    end
    7'h67: begin
      wr  = 1'b1;
      res = nxt;
      nxt = (a + imm_i) & ~32'd1;
    end
    7'h63: begin
      case (inst[14:12])
        3'd0: taken = (a == b);
        3'd1: taken = (a != b);
        3'd4: taken = ($signed(a) < $signed(b));
        3'd5: taken = ($signed(a) >= $signed(b));
        3'd6: taken = (a < b);
        3'd7: taken = (a >= b);
        default: taken = 1'b0;
      endcase
      if (taken) nxt = ref_pc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    end
    7'h03: begin
      addr = a + imm_i;
      word = ref_mem[addr[8:2]] >> (8 * addr[1:0]);
      wr   = 1'b1;
      case (inst[14:12])
        3'd0: res = {{24{word[7]}}, word[7:0]};
        3'd1: res = {{16{word[15]}}, word[15:0]};
        3'd4: res = {24'b0, word[7:0]};
        3'd5: res = {16'b0, word[15:0]};
        default: res = word;
      endcase
    end
    7'h23: begin
      addr    = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
      st_we   = 1'b1;
      st_addr = addr;
      st_data = b;                                 // sw
      st_strb = 4'b1111;
      if (inst[14:12] == 3'd0) begin
        st_data             = {4{b[7:0]}};
        st_strb             = 4'b0000;
        st_strb[addr[1:0]]  = 1'b1;                // one lane per byte offset
      end else if (inst[14:12] == 3'd1) begin
        st_data = {2{b[15:0]}};
        st_strb = addr[1] ? 4'b1100 : 4'b0011;     // upper or lower half
      end
      for (int i = 0; i < 4; i++) begin
        if (st_strb[i]) ref_mem[addr[8:2]][8*i +: 8] = st_data[8*i +: 8];
      end
    end
    7'h13: begin
      wr  = 1'b1;
      res = alu_ref(inst[14:12], inst[30] && (inst[14:12] == 3'd5), a, imm_i);
    end
    7'h33: begin
      wr  = 1'b1;
      res = alu_ref(inst[14:12], inst[30], a, b);
    end
    7'h73: begin
      if (inst == 32'h0010_0073) begin
        ref_halted = 1'b1;
        nxt        = ref_pc;                       // pc freezes on ebreak
      end
    end
    default: ;                                     // anything else retires as a nop
  endcase
  if (wr && (inst[11:7] != 5'd0)) ref_x[inst[11:7]] = res;
  ref_pc = nxt;
endtask

`endif

//--- tb/tb_rv_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rv_core;

  localparam logic [31:0] reset_pc    = 32'h8000_0000;
  localparam logic [31:0] ebreak_inst = 32'h0010_0073;

  logic        clk = 1'b0;
  logic        rst_n = 1'b0;
  logic [31:0] imem_addr;
  logic [31:0] imem_rdata;
  logic [31:0] dmem_addr;
  logic        dmem_we;
  logic [3:0]  dmem_wstrb;
  logic [31:0] dmem_wdata;
  logic [31:0] dmem_rdata;
  logic        halted;

  logic [31:0] prog [0:255];
  logic        is_target [0:255];   // landing spots of forward jumps
  logic [31:0] dmem [0:127];
  logic [31:0] lfsr = 32'h59b7519c;
  int          cycles;

  `include "rv_iss.svh"

  rv_core_top #(.reset_pc(reset_pc)) rv_core_top_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .imem_addr  (imem_addr),
    .imem_rdata (imem_rdata),
    .dmem_addr  (dmem_addr),
    .dmem_we    (dmem_we),
    .dmem_wstrb (dmem_wstrb),
    .dmem_wdata (dmem_wdata),
    .dmem_rdata (dmem_rdata),
    .halted     (halted)
  );

  always #5 clk = ~clk;

  assign imem_rdata = prog[imem_addr[9:2]];
  assign dmem_rdata = dmem[dmem_addr[8:2]];

  always @(posedge clk) begin
    if (dmem_we) begin
      for (int i = 0; i < 4; i++) begin
        if (dmem_wstrb[i]) dmem[dmem_addr[8:2]][8*i +: 8] <= dmem_wdata[8*i +: 8];
      end
    end
  end

  // galois lfsr stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return v;
  endfunction

  function automatic logic [31:0] fill_word(input logic [31:0] a);
    return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h3c6e_f372;
  endfunction

  function automatic logic [31:0] itype_word(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] stype_word(input logic [11:0] imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] btype_word(input logic [12:0] imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] jtype_word(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  // aligned x0-based offset inside the 256-byte region
  function automatic logic [11:0] data_offset(input logic [2:0] f3, input logic [7:0] a);
    case (f3[1:0])
      2'd1: return {4'b0, a[7:1], 1'b0};
      2'd2: return {4'b0, a[7:2], 2'b00};
      default: return {4'b0, a};
    endcase
  endfunction

  task automatic gen_program();
    int          n;
    int          k;
    logic [3:0]  kind;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [11:0] imm;
    for (int i = 0; i < 256; i++) begin
      prog[i]      = ebreak_inst;
      is_target[i] = 1'b0;
    end
    n = 0;
    while (n < 200) begin
      kind = 4'(rand_bits(4));
      rd   = 5'(rand_bits(5));
      rs1  = 5'(rand_bits(5));
      rs2  = 5'(rand_bits(5));
      f3   = 3'(rand_bits(3));
      imm  = 12'(rand_bits(12));
      k    = 2 + int'(rand_bits(2));    // forward distance 2..5
      case (kind)
        4'd0, 4'd1, 4'd2, 4'd3, 4'd4: begin
          imm     = {1'b0, imm[10] & (f3 == 3'd0 || f3 == 3'd5), 5'b0, rs2};
          prog[n] = itype_word(imm, rs1, f3, rd, 7'h33);
        end
        4'd5, 4'd6, 4'd7, 4'd8: begin
          if (f3 == 3'd1) imm[11:5] = 7'b0;                    // slli
          if (f3 == 3'd5) imm[11:5] = {1'b0, imm[10], 5'b0};  // srli or srai
          prog[n] = itype_word(imm, rs1, f3, rd, 7'h13);
        end
        4'd9:  prog[n] = itype_word(imm, rs1, f3, rd, 7'h37);  // lui
        4'd10: prog[n] = itype_word(imm, rs1, f3, rd, 7'h17);  // auipc
        4'd11: begin
          if (f3 == 3'd3 || f3 > 3'd5) f3 = 3'd2;
          prog[n] = itype_word(data_offset(f3, imm[7:0]), 5'd0, f3, rd, 7'h03);
        end
        4'd12: begin
          f3      = (f3[1:0] == 2'd3) ? 3'd2 : {1'b0, f3[1:0]};
          prog[n] = stype_word(data_offset(f3, imm[7:0]), rs2, 5'd0, f3);
        end
        4'd13: begin
          if (f3 == 3'd2 || f3 == 3'd3) f3 = f3 + 3'd2;
          prog[n]          = btype_word(13'(4 * k), rs2, rs1, f3);
          is_target[n + k] = 1'b1;
        end
        4'd14: begin
          prog[n]          = jtype_word(21'(4 * k), rd);
          is_target[n + k] = 1'b1;
        end
        default: begin
          if (is_target[n + 1]) begin
            prog[n] = itype_word(imm, rs1, 3'd0, rd, 7'h13);   // jalr must not be entered alone
          end else begin
            if (rs1 == 5'd0) rs1 = 5'd1;
            prog[n]     = itype_word(12'd0, 5'd0, 3'd0, rs1, 7'h17);
            prog[n + 1] = itype_word(12'(4 * k + 4) | {11'b0, imm[0]}, rs1, 3'd0, rd, 7'h67);
            is_target[n + 1 + k] = 1'b1;
            n++;
          end
        end
      endcase
      n++;
    end
    for (int i = 0; i < 6; i++) begin
      prog[n] = 32'h0000_0013;    // landing pad for late jumps
      n++;
    end
    for (int r = 1; r < 32; r++) begin
      prog[n] = stype_word(12'(256 + 4 * (r - 1)), 5'(r), 5'd0, 3'd2);
      n++;
    end
    prog[n] = ebreak_inst;
  endtask

  task automatic stop_on_error();
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL at %0d ns: %s got %h expected %h", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  // sampled mid-cycle when combinational paths have settled
  task automatic check_cycle();
    logic        st_we;
    logic [31:0] st_addr;
    logic [3:0]  st_strb;
    logic [31:0] st_data;
    logic [31:0] mask;
    check_value("imem_addr", imem_addr, ref_pc);
    check_value("halted", {31'b0, halted}, {31'b0, ref_halted});
    step_model(st_we, st_addr, st_strb, st_data);
    check_value("dmem_we", {31'b0, dmem_we}, {31'b0, st_we});
    if (st_we) begin
      mask = {{8{st_strb[3]}}, {8{st_strb[2]}}, {8{st_strb[1]}}, {8{st_strb[0]}}};
      check_value("dmem_addr", dmem_addr, st_addr);
      check_value("dmem_wstrb", {28'b0, dmem_wstrb}, {28'b0, st_strb});
      check_value("dmem_wdata", dmem_wdata & mask, st_data & mask);
    end
  endtask

  initial begin
    gen_program();
    for (int i = 0; i < 128; i++) begin
      dmem[i]    = fill_word(32'(i * 4));
      ref_mem[i] = fill_word(32'(i * 4));
    end
    for (int i = 0; i < 32; i++) begin
      ref_x[i] = '0;
    end
    ref_pc     = reset_pc;
    ref_halted = 1'b0;

    repeat (15) @(posedge clk);
    @(negedge clk);
    check_value("imem_addr", imem_addr, reset_pc);
    check_value("halted", {31'b0, halted}, 32'd0);
    check_value("dmem_we", {31'b0, dmem_we}, 32'd0);
    @(posedge clk);
    #1 rst_n = 1'b1;

    cycles = 0;
    while (!ref_halted) begin
      @(negedge clk);
      check_cycle();
      cycles++;
      if (cycles > 2000) begin
        $display("timeout: program did not reach ebreak after %0d cycles", cycles);
        stop_on_error();
      end
    end

    // halted rises and pc and stores stay frozen
    for (int i = 0; i < 21; i++) begin
      @(negedge clk);
      check_cycle();
    end

    for (int i = 0; i < 128; i++) begin
      check_value($sformatf("dmem[%0d]", i), dmem[i], ref_mem[i]);
    end

    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire
